// File: tb.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/icache_refill.sv
hdl/icache_arrays.sv
hdl/fetch_ctrl.sv
hdl/fetch_queue.sv
hdl/fetch_top.sv
sim/wb_mem_model.sv
sim/tb_fetch.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_fetch > build.log 2>&1 &&
obj_dir/Vtb_fetch | tee sim.log
grep -q "RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: sim/tb_fetch.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module tb_fetch;

   localparam int          WAIT_LIMIT = 2000;   // cycles per wait
   localparam logic [31:0] CHAIN_PC   = 32'h040;
   localparam logic [31:0] LOOP_PC    = 32'h200;
   localparam logic [31:0] FAR_PC     = 32'h600;

   logic                       clk;
   logic                       reset;
   logic                       restart_valid;
   logic [`FETCH_ADDR_W-1:0]   restart_pc;
   logic                       restart_ack;
   logic                       flush_req;
   logic                       flush_complete;
   logic                       wb_cyc, wb_stb, wb_ack;
   logic [`FETCH_ADDR_W-1:0]   wb_adr;
   logic [31:0]                wb_dat;
   logic                       insn_valid, insn_taken, insn_ack;
   logic [`FETCH_ADDR_W-1:0]   insn_pc, insn_next_pc;
   logic [31:0]                insn_word;

   string       test_name = "";
   int          errors = 0;
   int          errors_base, taken_base;
   int          tests_passed = 0;
   int          tests_failed = 0;
   int          accepted = 0;     // entries taken by the consumer
   int          taken_seen = 0;
   int          cyc_seen = 0;     // cycles with wb_cyc high
   int          cyc_at_ack;
   logic [31:0] exp_pc, exp_word, exp_next, beat_base;
   logic        exp_taken;
   logic [1:0]  beat_no;

   fetch_top fetch_top_i (.*);

   wb_mem_model mem_i (.clk, .reset, .wb_cyc, .wb_stb, .wb_adr, .wb_dat, .wb_ack);

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #50 clk = ~clk;
      end
   end

   function automatic logic [31:0] encode_jal(input logic [4:0] rd, input logic [31:0] from,
                                              input logic [31:0] to);
      logic [31:0] off;
      off = to - from;
      return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
   endfunction

   // expected fetch of one pc, returns the next pc
   function automatic logic [31:0] predict_fetch(input logic [31:0] pc, output logic [31:0] word,
                                                 output logic taken);
      logic [31:0] imm;
      word  = mem_i.mem[pc[11:2]];
      taken = (word[6:0] == `OPC_JAL);
      imm   = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
      return taken ? pc + imm : pc + 32'd4;
   endfunction

   task automatic plant_jal(input logic [31:0] from, input logic [31:0] to, input logic [4:0] rd);
      mem_i.mem[from[11:2]] = encode_jal(rd, from, to);
   endtask

   task automatic fill_memory();
      logic [31:0] w;
      for (int i = 0; i < 1024; i++)
      begin
         w = $urandom;
         if (w[6:0] == `OPC_JAL)
         begin
            w[0] = 1'b0;   // never a jal by chance
         end
         mem_i.mem[i] = w;
      end
      plant_jal(32'h04c, 32'h300, 5'd0);
      plant_jal(32'h30c, 32'h0a0, 5'd1);   // backward
      plant_jal(32'h0b8, 32'h0c0, 5'd0);
      plant_jal(32'h0d4, 32'h404, 5'd0);   // lands mid-line
      plant_jal(32'h40c, 32'h0e0, 5'd1);
      plant_jal(32'h21c, 32'h200, 5'd0);   // closes the loop
      plant_jal(32'h620, 32'h6f8, 5'd1);
   endtask

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else
      begin
         $display("mismatch %s %s expected %h actual %h", test_name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic check_true(input logic cond, input string msg);
      assert (cond === 1'b1)
      else
      begin
         $display("error in %s: %s", test_name, msg);
         errors++;
      end
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      errors_base = errors;
      taken_base  = taken_seen;
   endtask

   task automatic finish_test();
      if (errors == errors_base)
      begin
         tests_passed++;
         $display("test %s passed", test_name);
      end
      else
      begin
         tests_failed++;
         $display("test %s failed with %0d errors", test_name, errors - errors_base);
      end
   endtask

   task automatic restart_fetch(input logic [31:0] pc);
      int   t;
      logic got;
      @(negedge clk);
      restart_valid = 1'b1;
      restart_pc    = pc;
      t   = 0;
      got = 1'b0;
      while (!got && t < WAIT_LIMIT)
      begin
         @(posedge clk);
         got = restart_ack;
         t++;
      end
      cyc_at_ack = cyc_seen;
      @(negedge clk);
      restart_valid = 1'b0;
      check_true(got, "restart_ack never arrived");
   endtask

   task automatic consume_entries(input int n, input logic stall);
      int target;
      int t;
      target = accepted + n;
      t = 0;
      @(negedge clk);
      while (accepted < target && t < WAIT_LIMIT)
      begin
         insn_ack = stall ? ($urandom % 3 != 0) : 1'b1;   // about a third stalled
         @(negedge clk);
         t++;
      end
      insn_ack = 1'b0;
      check_true(accepted >= target, "too few instructions arrived before the timeout");
   endtask

   task automatic flush_cache();
      int   t;
      logic done;
      @(negedge clk);
      flush_req = 1'b1;
      @(negedge clk);
      flush_req = 1'b0;
      t    = 0;
      done = 1'b0;
      while (!done && t < WAIT_LIMIT)
      begin
         @(posedge clk);
         done = flush_complete;
         t++;
      end
      check_true(done, "flush_complete never pulsed");
   endtask

   task automatic wait_insn_valid();
      int t;
      t = 0;
      while (!insn_valid && t < WAIT_LIMIT)
      begin
         @(negedge clk);
         t++;
      end
      check_true(insn_valid, "no instruction arrived after the restart");
   endtask

   // checker for every entry the consumer takes
   always @(posedge clk)
   begin
      if (!reset && restart_ack)
      begin
         exp_pc <= restart_pc;
      end
      else if (!reset && insn_valid && insn_ack)
      begin
         exp_next = predict_fetch(exp_pc, exp_word, exp_taken);
         check_value("pc", exp_pc, insn_pc);
         check_value("word", exp_word, insn_word);
         check_value("taken", {31'd0, exp_taken}, {31'd0, insn_taken});
         check_value("next pc", exp_next, insn_next_pc);
         exp_pc     <= exp_next;
         accepted   <= accepted + 1;
         taken_seen <= taken_seen + (insn_taken ? 1 : 0);
      end
   end

   // bus monitor, four beats per line in address order
   always @(posedge clk)
   begin
      if (reset)
      begin
         beat_no <= 2'd0;
      end
      else
      begin
         if (wb_cyc)
         begin
            cyc_seen <= cyc_seen + 1;
            check_true(wb_stb, "wb_stb dropped inside a bus cycle");
         end
         else
         begin
            check_true(beat_no == 2'd0, "bus cycle ended before its fourth beat");
         end
         if (wb_cyc && wb_ack)
         begin
            if (beat_no == 2'd0)
            begin
               check_value("line offset", 32'd0, {28'd0, wb_adr[3:0]});
               beat_base <= wb_adr;
            end
            else
            begin
               check_value("beat address", beat_base + {28'd0, beat_no, 2'b00}, wb_adr);
            end
            beat_no <= beat_no + 2'd1;
         end
      end
   end

   initial
   begin
      void'($urandom(32'hc870cd3a));
      reset         = 1'b1;
      restart_valid = 1'b0;
      restart_pc    = '0;
      flush_req     = 1'b0;
      insn_ack      = 1'b0;
      fill_memory();
      repeat (5) @(negedge clk);
      reset = 1'b0;

      start_test("reset");
      repeat (20)
      begin
         @(negedge clk);
         check_true(!(restart_ack || flush_complete || wb_cyc || wb_stb || insn_valid),
                    "an output was active during the invalidate sweep");
      end
      finish_test();

      start_test("chain");
      restart_fetch(CHAIN_PC);
      consume_entries(40, 1'b0);
      check_value("taken entries", 32'd5, taken_seen - taken_base);
      finish_test();

      start_test("loop");
      restart_fetch(LOOP_PC);
      consume_entries(24, 1'b0);
      restart_fetch(LOOP_PC);
      consume_entries(16, 1'b0);
      check_value("bus cycles on refetch", cyc_at_ack, cyc_seen);   // all hits
      finish_test();

      start_test("stall");
      restart_fetch(CHAIN_PC);
      consume_entries(40, 1'b1);
      check_value("taken entries", 32'd5, taken_seen - taken_base);
      finish_test();

      start_test("restart");
      restart_fetch(CHAIN_PC);
      consume_entries(6, 1'b1);
      repeat (6) @(negedge clk);   // let the queue fill up
      restart_fetch(FAR_PC);
      consume_entries(20, 1'b1);
      finish_test();

      start_test("flush");
      restart_fetch(LOOP_PC);
      consume_entries(16, 1'b0);   // loop stays in two lines, both cached
      flush_cache();
      restart_fetch(LOOP_PC);
      wait_insn_valid();
      check_true(cyc_seen > cyc_at_ack, "no refill before the first instruction after flush");
      consume_entries(10, 1'b0);
      finish_test();

      $display("%0d tests, %0d passed, %0d failed, %0d instructions checked, %0d errors",
               tests_passed + tests_failed, tests_passed, tests_failed, accepted, errors);
      if (errors == 0 && tests_failed == 0)
      begin
         $display("RESULT: PASS");
      end
      else
      begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: sim/wb_mem_model.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module wb_mem_model (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       wb_cyc,
   input  logic                       wb_stb,
   input  logic [`FETCH_ADDR_W-1:0]   wb_adr,
   output logic [31:0]                wb_dat,
   output logic                       wb_ack
);

   logic [31:0]  mem [1024];      // loaded by the testbench
   logic         ack_q = 1'b0;
   logic [31:0]  dat_q = '0;
   logic [1:0]   delay;           // wait cycles left in this beat

   assign wb_ack = ack_q;
   assign wb_dat = dat_q;

   always @(posedge clk)
   begin
      if (reset)
      begin
         ack_q <= 1'b0;
         delay <= 2'd0;
      end
      else if (ack_q)
      begin
         ack_q <= 1'b0;   // single-cycle ack
         delay <= 2'($urandom % 4);
      end
      else if (wb_cyc && wb_stb)
      begin
         if (delay == 2'd0)
         begin
            ack_q <= 1'b1;
            dat_q <= mem[wb_adr[11:2]];
         end
         else
         begin
            delay <= delay - 2'd1;
         end
      end
   end

endmodule

// File: hdl/fetch_top.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_top (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       restart_valid,
   input  logic [`FETCH_ADDR_W-1:0]   restart_pc,
   output logic                       restart_ack,
   input  logic                       flush_req,
   output logic                       flush_complete,
   output logic                       wb_cyc,
   output logic                       wb_stb,
   output logic [`FETCH_ADDR_W-1:0]   wb_adr,
   input  logic [31:0]                wb_dat,
   input  logic                       wb_ack,
   output logic                       insn_valid,
   output logic [`FETCH_ADDR_W-1:0]   insn_pc,
   output logic [31:0]                insn_word,
   output logic                       insn_taken,
   output logic [`FETCH_ADDR_W-1:0]   insn_next_pc,
   input  logic                       insn_ack
);

   logic                            refill_start, line_wr, valid_out, inv_en;
   logic [`FETCH_ADDR_W-1:0]        refill_addr, push_pc, push_next_pc;
   logic [`LG_SETS-1:0]             line_idx, rd_idx, inv_idx;
   logic [`TAG_W-1:0]               line_tag, tag_out;
   logic [`LINE_BITS-1:0]           line_data, data_out;
   logic [`WORDS_PER_LINE-1:0]      line_jump, jump_out;
   logic                            push, push_taken, clear, full;
   logic [31:0]                     push_word;

   icache_refill refill_i (
      .clk, .reset, .refill_start, .refill_addr, .wb_dat, .wb_ack,
      .wb_cyc, .wb_stb, .wb_adr,
      .line_wr, .line_idx, .line_tag, .line_data, .line_jump
   );

   icache_arrays arrays_i (
      .clk, .reset, .rd_idx,
      .line_wr, .line_idx, .line_tag, .line_data, .line_jump,
      .inv_en, .inv_idx,
      .valid_out, .tag_out, .data_out, .jump_out
   );

   fetch_ctrl ctrl_i (
      .clk, .reset, .restart_valid, .restart_pc, .flush_req,
      .valid_out, .tag_out, .data_out, .jump_out, .line_wr, .full,
      .restart_ack, .flush_complete, .rd_idx, .inv_en, .inv_idx,
      .refill_start, .refill_addr,
      .push, .push_pc, .push_word, .push_taken, .push_next_pc, .clear
   );

   fetch_queue fq_i (
      .clk, .reset, .push, .push_pc, .push_word, .push_taken, .push_next_pc,
      .clear, .insn_ack, .full,
      .insn_valid, .insn_pc, .insn_word, .insn_taken, .insn_next_pc
   );

endmodule

// File: hdl/fetch_queue.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_queue
   import fetch_pkg::*;
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       push,
   input  logic [`FETCH_ADDR_W-1:0]   push_pc,
   input  logic [31:0]                push_word,
   input  logic                       push_taken,
   input  logic [`FETCH_ADDR_W-1:0]   push_next_pc,
   input  logic                       clear,
   input  logic                       insn_ack,
   output logic                       full,
   output logic                       insn_valid,
   output logic [`FETCH_ADDR_W-1:0]   insn_pc,
   output logic [31:0]                insn_word,
   output logic                       insn_taken,
   output logic [`FETCH_ADDR_W-1:0]   insn_next_pc
);

   localparam int N = 1 << `LG_FQ_ENTRIES;

   logic [`LG_FQ_ENTRIES:0]         head, tail;   // msb is the wrap bit
   logic [`FETCH_ADDR_W-1:0]        pc_q      [N];
   logic [31:0]                     word_q    [N];
   logic                            taken_q   [N];
   logic [`FETCH_ADDR_W-1:0]        next_pc_q [N];

   assign full = (head[`LG_FQ_ENTRIES] != tail[`LG_FQ_ENTRIES]) &&
                 (head[`LG_FQ_ENTRIES-1:0] == tail[`LG_FQ_ENTRIES-1:0]);
   assign insn_valid   = (head != tail);
   assign insn_pc      = pc_q[head[`LG_FQ_ENTRIES-1:0]];
   assign insn_word    = word_q[head[`LG_FQ_ENTRIES-1:0]];
   assign insn_taken   = taken_q[head[`LG_FQ_ENTRIES-1:0]];
   assign insn_next_pc = next_pc_q[head[`LG_FQ_ENTRIES-1:0]];

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         head <= '0;
         tail <= '0;
      end
      else
      begin
         if (push && !full)
         begin
            tail <= tail + 1'b1;
         end
         if (insn_valid && insn_ack)
         begin
            head <= head + 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (push && !full)
      begin
         pc_q[tail[`LG_FQ_ENTRIES-1:0]]      <= push_pc;
         word_q[tail[`LG_FQ_ENTRIES-1:0]]    <= push_word;
         taken_q[tail[`LG_FQ_ENTRIES-1:0]]   <= push_taken;
         next_pc_q[tail[`LG_FQ_ENTRIES-1:0]] <= push_next_pc;
      end
   end

endmodule

// File: hdl/fetch_ctrl.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_ctrl
   import fetch_pkg::*;
(
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          restart_valid,
   input  logic [`FETCH_ADDR_W-1:0]      restart_pc,
   input  logic                          flush_req,
   input  logic                          valid_out,
   input  logic [`TAG_W-1:0]             tag_out,
   input  logic [`LINE_BITS-1:0]         data_out,
   input  logic [`WORDS_PER_LINE-1:0]    jump_out,
   input  logic                          line_wr,
   input  logic                          full,
   output logic                          restart_ack,
   output logic                          flush_complete,
   output logic [`LG_SETS-1:0]           rd_idx,
   output logic                          inv_en,
   output logic [`LG_SETS-1:0]           inv_idx,
   output logic                          refill_start,
   output logic [`FETCH_ADDR_W-1:0]      refill_addr,
   output logic                          push,
   output logic [`FETCH_ADDR_W-1:0]      push_pc,
   output logic [31:0]                   push_word,
   output logic                          push_taken,
   output logic [`FETCH_ADDR_W-1:0]      push_next_pc,
   output logic                          clear
);

   localparam int A      = `FETCH_ADDR_W;
   localparam int IDX_LO = `LG_LINE_BYTES;
   localparam int IDX_HI = `LG_LINE_BYTES + `LG_SETS;
   localparam int SETS   = 1 << `LG_SETS;

   localparam logic [2:0] S_INIT   = 3'd0;   // invalidate sweep
   localparam logic [2:0] S_IDLE   = 3'd1;
   localparam logic [2:0] S_ACTIVE = 3'd2;
   localparam logic [2:0] S_REFILL = 3'd3;
   localparam logic [2:0] S_WAIT   = 3'd4;   // queue full

   logic [2:0]                   state, state_n;
   logic [A-1:0]                 pc, pc_n;             // next pc to read
   logic [A-1:0]                 look_pc, look_pc_n;   // pc being checked
   logic                         look_vld, look_vld_n;
   logic [`LG_SETS-1:0]          sweep_idx, sweep_idx_n;
   logic                         flush_pend, flush_pend_n;
   logic                         can_redirect, take_flush, take_restart;
   logic                         hit, miss;
   logic [`LG_LINE_BYTES-3:0]    word_sel;
   insn_word_u                   look_word;
   logic                         look_jump;
   logic [A-1:0]                 jal_target;

   // check stage, one cycle behind the read
   always_comb
   begin
      word_sel  = look_pc[IDX_LO-1:2];
      look_word = data_out[word_sel*32 +: 32];
      look_jump = jump_out[word_sel];
      jal_target = look_pc + {{(A-20){look_word.j.imm20}}, look_word.j.imm19_12,
                              look_word.j.imm11, look_word.j.imm10_1, 1'b0};
      hit  = look_vld && valid_out && (tag_out == look_pc[A-1:IDX_HI]);
      miss = look_vld && !hit;
   end

   assign push_pc      = look_pc;
   assign push_word    = look_word;
   assign push_taken   = look_jump;
   assign push_next_pc = look_jump ? jal_target : look_pc + 4;
   assign refill_addr  = {look_pc[A-1:IDX_LO], {IDX_LO{1'b0}}};
   assign inv_idx      = sweep_idx;

   // no redirect in the middle of a bus cycle
   assign can_redirect = (state == S_IDLE) || (state == S_ACTIVE) || (state == S_WAIT);
   assign take_flush   = can_redirect && flush_pend;
   assign take_restart = can_redirect && !flush_pend && restart_valid;

   always_comb
   begin
      state_n        = state;
      pc_n           = pc;
      look_pc_n      = pc;
      look_vld_n     = 1'b0;
      sweep_idx_n    = sweep_idx;
      flush_pend_n   = flush_pend | flush_req;
      rd_idx         = pc[IDX_HI-1:IDX_LO];
      inv_en         = 1'b0;
      refill_start   = 1'b0;
      push           = 1'b0;
      flush_complete = 1'b0;
      clear          = take_flush | take_restart;
      restart_ack    = take_restart;
      if (take_flush)
      begin
         state_n     = S_INIT;
         sweep_idx_n = '0;
      end
      else if (take_restart)
      begin
         state_n = S_ACTIVE;   // in-flight read dropped
         pc_n    = restart_pc;
      end
      else
      begin
         case (state)
            S_INIT:
            begin
               inv_en      = 1'b1;
               sweep_idx_n = sweep_idx + 1'b1;
               if (sweep_idx == SETS - 1)
               begin
                  state_n        = S_IDLE;
                  flush_complete = flush_pend;   // silent after reset
                  flush_pend_n   = flush_req;
               end
            end
            S_ACTIVE:
            begin
               if (miss)
               begin
                  refill_start = 1'b1;
                  pc_n         = look_pc;   // reread once the line is in
                  state_n      = S_REFILL;
               end
               else if (hit && full)
               begin
                  pc_n    = look_pc;
                  state_n = S_WAIT;
               end
               else
               begin
                  push = hit;
                  if (hit && look_jump)
                  begin
                     pc_n = jal_target;   // one bubble
                  end
                  else
                  begin
                     look_vld_n = 1'b1;
                     pc_n       = pc + 4;
                  end
               end
            end
            S_REFILL:
            begin
               if (line_wr)
               begin
                  state_n = S_ACTIVE;
               end
            end
            S_WAIT:
            begin
               if (!full)
               begin
                  look_vld_n = 1'b1;
                  pc_n       = pc + 4;
                  state_n    = S_ACTIVE;
               end
            end
            default:
            begin
               state_n = S_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state      <= S_INIT;
         look_vld   <= 1'b0;
         sweep_idx  <= '0;
         flush_pend <= 1'b0;
      end
      else
      begin
         state      <= state_n;
         look_vld   <= look_vld_n;
         sweep_idx  <= sweep_idx_n;
         flush_pend <= flush_pend_n;
      end
      pc      <= pc_n;
      look_pc <= look_pc_n;
   end

endmodule

// File: hdl/icache_arrays.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module icache_arrays
   import fetch_pkg::*;
(
   input  logic                          clk,
   input  logic                          reset,
   input  logic [`LG_SETS-1:0]           rd_idx,
   input  logic                          line_wr,
   input  logic [`LG_SETS-1:0]           line_idx,
   input  logic [`TAG_W-1:0]             line_tag,
   input  logic [`LINE_BITS-1:0]         line_data,
   input  logic [`WORDS_PER_LINE-1:0]    line_jump,
   input  logic                          inv_en,
   input  logic [`LG_SETS-1:0]           inv_idx,
   output logic                          valid_out,
   output logic [`TAG_W-1:0]             tag_out,
   output logic [`LINE_BITS-1:0]         data_out,
   output logic [`WORDS_PER_LINE-1:0]    jump_out
);

   localparam int SETS = 1 << `LG_SETS;

   logic [SETS-1:0]               vld;
   logic [`TAG_W-1:0]             tag_mem  [SETS];
   logic [`LINE_BITS-1:0]         data_mem [SETS];
   logic [`WORDS_PER_LINE-1:0]    jump_mem [SETS];

   // valid bits are cleared by the controller's sweep
   always_ff @(posedge clk)
   begin
      if (line_wr)
      begin
         vld[line_idx]      <= 1'b1;
         tag_mem[line_idx]  <= line_tag;
         data_mem[line_idx] <= line_data;
         jump_mem[line_idx] <= line_jump;
      end
      if (inv_en)
      begin
         vld[inv_idx] <= 1'b0;
      end
   end

   // registered read, old contents on a same-cycle write
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         valid_out <= 1'b0;
      end
      else
      begin
         valid_out <= vld[rd_idx];
      end
      tag_out  <= tag_mem[rd_idx];
      data_out <= data_mem[rd_idx];
      jump_out <= jump_mem[rd_idx];
   end

endmodule

// File: hdl/icache_refill.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module icache_refill
   import fetch_pkg::*;
(
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           refill_start,
   input  logic [`FETCH_ADDR_W-1:0]       refill_addr,
   input  logic [31:0]                    wb_dat,
   input  logic                           wb_ack,
   output logic                           wb_cyc,
   output logic                           wb_stb,
   output logic [`FETCH_ADDR_W-1:0]       wb_adr,
   output logic                           line_wr,
   output logic [`LG_SETS-1:0]            line_idx,
   output logic [`TAG_W-1:0]              line_tag,
   output logic [`LINE_BITS-1:0]          line_data,
   output logic [`WORDS_PER_LINE-1:0]     line_jump
);

   localparam int IDX_LO = `LG_LINE_BYTES;
   localparam int IDX_HI = `LG_LINE_BYTES + `LG_SETS;

   logic                              busy;
   logic [`LG_LINE_BYTES-3:0]         beat;      // word within the line
   logic [`FETCH_ADDR_W-1:IDX_LO]     line_addr;
   insn_word_u                        ack_word;
   logic                              ack_is_jal;

   // one beat per word, cyc held over the whole line
   assign wb_cyc = busy;
   assign wb_stb = busy;
   assign wb_adr = {line_addr, beat, 2'b00};

   assign line_idx = line_addr[IDX_HI-1:IDX_LO];
   assign line_tag = line_addr[`FETCH_ADDR_W-1:IDX_HI];

   // predecode keeps only the jal/j bit
   assign ack_word   = wb_dat;
   assign ack_is_jal = (ack_word.f.opcode == `OPC_JAL);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy    <= 1'b0;
         beat    <= '0;
         line_wr <= 1'b0;
      end
      else
      begin
         line_wr <= 1'b0;
         if (!busy && refill_start)
         begin
            busy <= 1'b1;
            beat <= '0;
         end
         else if (busy && wb_ack)
         begin
            beat <= beat + 1'b1;
            if (beat == `WORDS_PER_LINE - 1)
            begin
               busy    <= 1'b0;
               line_wr <= 1'b1;   // a cycle after the last ack
            end
         end
      end
   end

   // line payload, words shift in from the top
   always_ff @(posedge clk)
   begin
      if (!busy && refill_start)
      begin
         line_addr <= refill_addr[`FETCH_ADDR_W-1:IDX_LO];
      end
      if (busy && wb_ack)
      begin
         line_data <= {wb_dat, line_data[`LINE_BITS-1:32]};
         line_jump <= {ack_is_jal, line_jump[`WORDS_PER_LINE-1:1]};
      end
   end

endmodule

// File: hdl/fetch_pkg.sv
package fetch_pkg;

   // one instruction word seen two ways
   typedef union packed {
      // base field layout, used by predecode
      struct packed {
         logic [11:0] upper;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } f;
      // J-type layout, immediate bits scattered
      struct packed {
         logic        imm20;    // sign bit
         logic [9:0]  imm10_1;
         logic        imm11;
         logic [7:0]  imm19_12;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } j;
   } insn_word_u;

endpackage

// File: hdl/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// address and cache geometry
`define FETCH_ADDR_W   32
`define LG_SETS        4
`define LG_LINE_BYTES  4
`define WORDS_PER_LINE 4
`define LINE_BITS      (`WORDS_PER_LINE * 32)
`define TAG_W          (`FETCH_ADDR_W - `LG_SETS - `LG_LINE_BYTES)

// fetch queue depth, 8 entries
`define LG_FQ_ENTRIES  3

// jal and j share this opcode
`define OPC_JAL        7'h6f

`endif
